// ==== dv/boardTop_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop_asserts
#(
   parameter bit TIMER_CHECKS = 1'b1,
   parameter bit SCAN_CHECKS  = 1'b1
)
(
   input wire                        selected_clk,
   input wire                        res,
   input wire                        run,
   input wire                        clear,
   input wire [boardPkg::DATA_W-1:0] tmr,
   input wire [boardPkg::DATA_W-1:0] ctr,
   input wire [boardPkg::DATA_W-1:0] arrValue,
   input wire [boardPkg::DIGITS-1:0] an
);

   // ***********************************************************
   // Timer properties
   // ***********************************************************
   if (TIMER_CHECKS)
   begin : gTimer
      tmrInRange: assert property (@(posedge selected_clk) disable iff (res)
         run |-> tmr <= arrValue)
         else $error("Timer value is above the reload value while running.");

      clearZeroes: assert property (@(posedge selected_clk) disable iff (res)
         clear |=> (tmr == '0 && ctr == '0))
         else $error("Timer or event counter is not zero after clear.");
   end

   // ***********************************************************
   // Scanner property
   // ***********************************************************
   if (SCAN_CHECKS)
   begin : gScan
      anOneLow: assert property (@(posedge selected_clk) disable iff (res)
         $onehot0(~an))
         else $error("More than one display digit is enabled.");
   end

endmodule

bind timerUnit boardTop_asserts #(.SCAN_CHECKS (1'b0)) u_timerAsserts (
   .selected_clk (selected_clk),
   .res          (res),
   .run          (tt.run),
   .clear        (tt.clear),
   .tmr          (tt.tmr),
   .ctr          (tt.ctr),
   .arrValue     (tt.arrValue),
   .an           ({boardPkg::DIGITS{1'b1}})  // The timer drives no digit enables.
);

// The scanner carries only the digit check.
bind displayScan boardTop_asserts #(.TIMER_CHECKS (1'b0)) u_scanAsserts (
   .selected_clk (selected_clk),
   .res          (res),
   .run          (1'b0),
   .clear        (1'b0),
   .tmr          (tmr),
   .ctr          (ctr),
   .arrValue     (arrValue),
   .an           (an)
);

`default_nettype wire

// ==== dv/boardTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop_tb;
   import boardPkg::*;

   localparam int SAMPLE_DIV = 4;
   localparam int TIMER_DIV = 3;
   localparam int SCAN_DIV = 2;
   localparam int CLK_PERIOD = 20;
   localparam int NUM_ROWS = 15;
   localparam int CAPTURE_LIMIT = 4 * DIGITS * SCAN_DIV;  // Two full sweeps and more.
   localparam int CTR_GAP = 20;
   localparam int ROW_CYCLES = 6 * SAMPLE_DIV + 4 + 3 * CAPTURE_LIMIT + CTR_GAP;
   localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + 200;

   // Active-low {g,f,e,d,c,b,a} for the hex digits 0 to F.
   localparam logic [6:0] SEG_CODES [0:15] = '{
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
   };

   typedef enum {CHK_NONE, CHK_LEDS, CHK_DISP, CHK_BOTH, CHK_DISP_LE, CHK_CTR_STABLE} checkT;

   logic              selected_clk;
   logic              res;
   logic [SW_W-1:0]   sw;
   logic              btnC;
   logic [SW_W-1:0]   leds;
   logic [7:0]        seg;
   logic [DIGITS-1:0] an;

   string             rowName [NUM_ROWS];
   bit                rowPress [NUM_ROWS];
   logic [SW_W-1:0]   rowSw [NUM_ROWS];
   checkT             rowKind [NUM_ROWS];
   logic [DATA_W-1:0] rowExp [NUM_ROWS];
   int                rowCount;
   int                errorCount;
   int                failedTests;
   integer            seed;

   boardTop #(
      .SAMPLE_DIV (SAMPLE_DIV),
      .TIMER_DIV  (TIMER_DIV),
      .SCAN_DIV   (SCAN_DIV)
   ) u_boardTop (
      .selected_clk (selected_clk),
      .res          (res),
      .sw           (sw),
      .btnC         (btnC),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   initial
   begin
      selected_clk = 1'b0;
      forever #(CLK_PERIOD / 2) selected_clk = ~selected_clk;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before all tests finished.");
      $display("*** FAILED ***");
      $finish;
   end

   task automatic waitCycles(input int n);
      repeat (n) @(posedge selected_clk);
   endtask

   // ***********************************************************
   // Button press and release, each followed by three sample periods
   // ***********************************************************
   task automatic pressCommand(input logic [SW_W-1:0] swVal);
      @(posedge selected_clk);
      #2;
      sw = swVal;
      btnC = 1'b1;
      waitCycles(3 * SAMPLE_DIV);
      #2;
      btnC = 1'b0;
      waitCycles(3 * SAMPLE_DIV);
   endtask

   function automatic int segToHex(input logic [6:0] pattern);
      int found;
      found = -1;
      for (int i = 0; i < 16; i++)
         if (SEG_CODES[i] == pattern)
            found = i;
      return found;
   endfunction

   // Reads every digit once from the scanned outputs.
   task automatic captureDisplay(output logic [DATA_W-1:0] value);
      logic [DIGITS-1:0] seen;
      logic [2:0]        idx;
      int                lowCount;
      int                nib;
      int                cycles;
      seen = '0;
      value = '0;
      cycles = 0;
      while (seen != '1 && cycles < CAPTURE_LIMIT)
      begin
         @(negedge selected_clk);
         cycles++;
         lowCount = 0;
         idx = '0;
         for (int i = 0; i < DIGITS; i++)
            if (!an[i])
            begin
               idx = 3'(i);
               lowCount++;
            end
         if (lowCount == 1)
         begin
            nib = segToHex(seg[6:0]);
            assert (nib >= 0 && seg[7])
            else
            begin
               $display("Error: pattern %b on digit %0d is not a hex digit", seg, idx);
               errorCount++;
            end
            value[{idx, 2'b00} +: 4] = nib[3:0];
            seen[idx] = 1'b1;
         end
      end
      assert (seen == '1)
      else
      begin
         $display("The display scan did not visit all eight digits.");
         errorCount++;
      end
   endtask

   task automatic reportValue(input int r, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
      $display("Error: %s expected %h actual %h", rowName[r], exp, act);
      errorCount++;
   endtask

   task automatic addRow(input string name, input bit press, input logic [SW_W-1:0] swVal,
                         input checkT kind, input logic [DATA_W-1:0] expected);
      rowName[rowCount] = name;
      rowPress[rowCount] = press;
      rowSw[rowCount] = swVal;
      rowKind[rowCount] = kind;
      rowExp[rowCount] = expected;
      rowCount++;
   endtask

   // ***********************************************************
   // Command table
   // ***********************************************************
   task automatic buildTable();
      logic [11:0] ledOp;
      logic [11:0] arrOp;
      logic [11:0] smallArr;
      logic [11:0] junk;
      ledOp = 12'($random(seed));
      arrOp = 12'($random(seed));
      smallArr = 12'(1 + ($random(seed) & 3));  // Short period so ctr moves.
      junk = 12'($random(seed));
      addRow("reset_state", 1'b0, 16'h0000, CHK_BOTH, 32'd0);
      addRow("set_leds", 1'b1, {4'h1, ledOp}, CHK_LEDS, 32'(ledOp));
      addRow("show_leds", 1'b1, 16'h6000, CHK_DISP, 32'(ledOp));
      addRow("load_arr", 1'b1, {4'h2, arrOp}, CHK_LEDS, 32'(ledOp));
      addRow("show_arr", 1'b1, 16'h6003, CHK_DISP, 32'(arrOp));
      addRow("load_small_arr", 1'b1, {4'h2, smallArr}, CHK_DISP, 32'(smallArr));
      addRow("start_timer", 1'b1, 16'h3000, CHK_NONE, 32'd0);
      addRow("stop_timer", 1'b1, 16'h4000, CHK_NONE, 32'd0);
      addRow("show_tmr", 1'b1, 16'h6001, CHK_DISP_LE, 32'(smallArr));
      addRow("show_ctr", 1'b1, 16'h6002, CHK_CTR_STABLE, 32'd0);
      addRow("clear_timer", 1'b1, 16'h5000, CHK_DISP, 32'd0);
      addRow("show_tmr_clear", 1'b1, 16'h6001, CHK_DISP, 32'd0);
      addRow("show_ctr_clear", 1'b1, 16'h6002, CHK_DISP, 32'd0);
      addRow("show_leds_again", 1'b1, 16'h6000, CHK_DISP, 32'(ledOp));
      addRow("undefined_op", 1'b1, {4'hB, junk}, CHK_BOTH, 32'(ledOp));
   endtask

   task automatic runRow(input int r);
      logic [DATA_W-1:0] first;
      logic [DATA_W-1:0] second;
      int                errBefore;
      errBefore = errorCount;
      if (rowPress[r])
         pressCommand(rowSw[r]);
      @(negedge selected_clk);
      if (rowKind[r] == CHK_LEDS || rowKind[r] == CHK_BOTH)
         assert (leds == rowExp[r][SW_W-1:0])
         else reportValue(r, rowExp[r], 32'(leds));
      if (rowKind[r] == CHK_DISP || rowKind[r] == CHK_BOTH)
      begin
         captureDisplay(first);
         assert (first == rowExp[r]) else reportValue(r, rowExp[r], first);
      end
      if (rowKind[r] == CHK_DISP_LE)
      begin
         captureDisplay(first);
         assert (first <= rowExp[r])
         else
         begin
            $display("Error: %s expected at most %h actual %h", rowName[r], rowExp[r], first);
            errorCount++;
         end
      end
      if (rowKind[r] == CHK_CTR_STABLE)
      begin
         captureDisplay(first);
         waitCycles(CTR_GAP);
         captureDisplay(second);
         assert (first != '0)
         else
         begin
            $display("Error: %s expected nonzero actual %h", rowName[r], first);
            errorCount++;
         end
         assert (second == first) else reportValue(r, first, second);
      end
      if (errorCount != errBefore)
         failedTests++;
      $display("Test %-16s %s", rowName[r], (errorCount == errBefore) ? "ok" : "failed");
   endtask

   initial
   begin
      res = 1'b1;
      sw = '0;
      btnC = 1'b0;
      rowCount = 0;
      errorCount = 0;
      failedTests = 0;
      seed = 32'hc56f_ab81;
      buildTable();
      repeat (4) @(posedge selected_clk);
      #2;
      res = 1'b0;
      for (int r = 0; r < NUM_ROWS; r++)
         runRow(r);
      $display("Tests: %0d, failed: %0d, errors: %0d", NUM_ROWS, failedTests, errorCount);
      if (errorCount == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
verilator --binary --timing --assert -f verilog.f --top-module boardTop_tb -o boardTop_sim \
   && ./obj_dir/boardTop_sim > sim.log 2>&1 \
   ; cat sim.log \
   && grep -qxF '*** PASSED ***' sim.log \
   && echo "Simulation passed." \
   || { echo "Simulation did not pass, see sim.log."; exit 1; }

// ==== source/boardPkg.sv ====
`default_nettype none

package boardPkg;

   // ***********************************************************
   // Board dimensions
   // ***********************************************************
   localparam int DATA_W = 32;  // Timer, counter and display word width.
   localparam int SW_W = 16;    // Slide switches, also the LED count.
   localparam int DIGITS = 8;   // Seven-segment digits on the board.

   // Values that the display can be switched to.
   typedef enum logic [1:0]
   {
      SRC_LEDS = 2'd0,
      SRC_TMR  = 2'd1,
      SRC_CTR  = 2'd2,
      SRC_ARR  = 2'd3
   } displaySrcT;

endpackage

`default_nettype wire

// ==== source/boardTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop
#(
   parameter int SAMPLE_DIV = 1000000,
   parameter int TIMER_DIV  = 100000,
   parameter int SCAN_DIV   = 100000
)
(
   input  wire                          selected_clk,
   input  wire                          res,
   input  wire [boardPkg::SW_W-1:0]     sw,
   input  wire                          btnC,
   output logic [boardPkg::SW_W-1:0]    leds,
   output logic [7:0]                   seg,
   output logic [boardPkg::DIGITS-1:0]  an
);
   import boardPkg::*;
   import monitorPkg::*;

   logic            sampleTick;
   logic            timerTick;
   logic            scanTick;
   logic            cmdStrobe;
   opcodeT          cmdOpcode;
   logic [11:0]     cmdOperand;
   logic [SW_W-1:0] ledValue;
   displaySrcT      showSel;

   timerCtrlIf tcIf ();

   tickGen #(
      .SAMPLE_DIV (SAMPLE_DIV),
      .TIMER_DIV  (TIMER_DIV),
      .SCAN_DIV   (SCAN_DIV)
   ) u_tickGen (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .timerTick    (timerTick),
      .scanTick     (scanTick)
   );

   inputSampler u_inputSampler (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .sw           (sw),
      .btnC         (btnC),
      .cmdStrobe    (cmdStrobe),
      .cmdOpcode    (cmdOpcode),
      .cmdOperand   (cmdOperand)
   );

   monitorCtrl u_monitorCtrl (
      .selected_clk (selected_clk),
      .res          (res),
      .cmdStrobe    (cmdStrobe),
      .cmdOpcode    (cmdOpcode),
      .cmdOperand   (cmdOperand),
      .tc           (tcIf.ctrl),
      .ledValue     (ledValue),
      .showSel      (showSel)
   );

   timerUnit u_timerUnit (
      .selected_clk (selected_clk),
      .res          (res),
      .timerTick    (timerTick),
      .tt           (tcIf.timer)
   );

   displayScan u_displayScan (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .showSel      (showSel),
      .ledValue     (ledValue),
      .tmr          (tcIf.tmr),
      .ctr          (tcIf.ctr),
      .arrValue     (tcIf.arrValue),
      .seg          (seg),
      .an           (an)
   );

   assign leds = ledValue;

endmodule

`default_nettype wire

// ==== source/displayScan.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayScan
(
   input  wire                         selected_clk,
   input  wire                         res,
   input  wire                         scanTick,
   input  wire boardPkg::displaySrcT   showSel,
   input  wire [boardPkg::SW_W-1:0]    ledValue,
   input  wire [boardPkg::DATA_W-1:0]  tmr,
   input  wire [boardPkg::DATA_W-1:0]  ctr,
   input  wire [boardPkg::DATA_W-1:0]  arrValue,
   output logic [7:0]                  seg,
   output logic [boardPkg::DIGITS-1:0] an
);
   import boardPkg::*;

   localparam int IDX_W = $clog2(DIGITS);

   logic [DATA_W-1:0] srcWord;
   logic [IDX_W-1:0]  digitIdx;
   logic [IDX_W-1:0]  nextIdx;
   logic              scanActive;
   logic              nextActive;

   // Segments are {g,f,e,d,c,b,a}, low means lit.
   function automatic logic [6:0] hexToSeg(input logic [3:0] nib);
      case (nib)
         4'h0: hexToSeg = 7'b1000000;
         4'h1: hexToSeg = 7'b1111001;
         4'h2: hexToSeg = 7'b0100100;
         4'h3: hexToSeg = 7'b0110000;
         4'h4: hexToSeg = 7'b0011001;
         4'h5: hexToSeg = 7'b0010010;
         4'h6: hexToSeg = 7'b0000010;
         4'h7: hexToSeg = 7'b1111000;
         4'h8: hexToSeg = 7'b0000000;
         4'h9: hexToSeg = 7'b0010000;
         4'hA: hexToSeg = 7'b0001000;
         4'hB: hexToSeg = 7'b0000011;
         4'hC: hexToSeg = 7'b1000110;
         4'hD: hexToSeg = 7'b0100001;
         4'hE: hexToSeg = 7'b0000110;
         default: hexToSeg = 7'b0001110;
      endcase
   endfunction

   always_comb
   begin
      case (showSel)
         SRC_TMR: srcWord = tmr;
         SRC_CTR: srcWord = ctr;
         SRC_ARR: srcWord = arrValue;
         default: srcWord = DATA_W'(ledValue);
      endcase
   end

   // The first scanTick only enables the scan on digit 0.
   assign nextActive = scanActive || scanTick;
   assign nextIdx = (scanTick && scanActive)
                    ? ((digitIdx == IDX_W'(DIGITS - 1)) ? '0 : digitIdx + 1'b1)
                    : digitIdx;

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         scanActive <= 1'b0;
         digitIdx <= '0;
         an <= '1;
         seg <= '1;
      end
      else
      begin
         scanActive <= nextActive;
         digitIdx <= nextIdx;
         an <= nextActive ? ~(DIGITS'(1) << nextIdx) : '1;
         seg <= {1'b1, hexToSeg(srcWord[nextIdx * 4 +: 4])};  // Decimal point stays off.
      end
   end

endmodule

`default_nettype wire

// ==== source/inputSampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputSampler
(
   input  wire                      selected_clk,
   input  wire                      res,
   input  wire                      sampleTick,
   input  wire [boardPkg::SW_W-1:0] sw,
   input  wire                      btnC,
   output logic                     cmdStrobe,
   output monitorPkg::opcodeT       cmdOpcode,
   output logic [11:0]              cmdOperand
);
   import boardPkg::*;
   import monitorPkg::*;

   logic [SW_W-1:0] swSync1;
   logic [SW_W-1:0] swSync2;
   logic [SW_W-1:0] swSample;
   logic            btnSync1;
   logic            btnSync2;
   logic            btnSample;

   // ***********************************************************
   // Synchronisers
   // ***********************************************************
   always_ff @(posedge selected_clk)
   begin
      swSync1 <= sw;
      swSync2 <= swSync1;
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         btnSync1 <= 1'b0;
         btnSync2 <= 1'b0;
      end
      else
      begin
         btnSync1 <= btnC;
         btnSync2 <= btnSync1;
      end
   end

   // ***********************************************************
   // Slow sampling, which also rides over contact bounce
   // ***********************************************************
   always_ff @(posedge selected_clk)
   begin
      if (sampleTick)
         swSample <= swSync2;
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         btnSample <= 1'b0;
         cmdStrobe <= 1'b0;
      end
      else
      begin
         cmdStrobe <= sampleTick && btnSync2 && !btnSample;  // Press seen on this sample.
         if (sampleTick)
            btnSample <= btnSync2;
      end
   end

   assign cmdOpcode = opcodeT'(swSample[SW_W-1 -: 4]);
   assign cmdOperand = swSample[11:0];

endmodule

`default_nettype wire

// ==== source/monitorCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module monitorCtrl
(
   input  wire                       selected_clk,
   input  wire                       res,
   input  wire                       cmdStrobe,
   input  wire monitorPkg::opcodeT   cmdOpcode,
   input  wire [11:0]                cmdOperand,
   timerCtrlIf.ctrl                  tc,
   output logic [boardPkg::SW_W-1:0] ledValue,
   output boardPkg::displaySrcT      showSel
);
   import boardPkg::*;
   import monitorPkg::*;

   ctrlStateT   state;
   opcodeT      opLatch;
   logic [11:0] operandLatch;

   // Command fields are held for the execute cycle.
   always_ff @(posedge selected_clk)
   begin
      if (state == ST_IDLE && cmdStrobe)
      begin
         opLatch <= cmdOpcode;
         operandLatch <= cmdOperand;
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         state <= ST_IDLE;
         ledValue <= '0;
         showSel <= SRC_LEDS;
         tc.run <= 1'b0;
         tc.arrValue <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (cmdStrobe)
                  state <= ST_EXEC;
            ST_EXEC:
            begin
               state <= ST_IDLE;
               case (opLatch)
                  OP_SET_LEDS: ledValue <= SW_W'(operandLatch);
                  OP_LOAD_ARR: tc.arrValue <= DATA_W'(operandLatch);
                  OP_START:    tc.run <= 1'b1;
                  OP_STOP:     tc.run <= 1'b0;
                  OP_SHOW:     showSel <= displaySrcT'(operandLatch[1:0]);
                  default:     ;  // OP_CLEAR only pulses, unknown codes are ignored.
               endcase
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Timer strobes are live for the whole execute cycle.
   assign tc.clear = (state == ST_EXEC) && (opLatch == OP_CLEAR);
   assign tc.loadArr = (state == ST_EXEC) && (opLatch == OP_LOAD_ARR);

endmodule

`default_nettype wire

// ==== source/monitorPkg.sv ====
`default_nettype none

package monitorPkg;

   // Command opcode, taken from the upper switch nibble.
   typedef enum logic [3:0]
   {
      OP_NOP      = 4'd0,
      OP_SET_LEDS = 4'd1,
      OP_LOAD_ARR = 4'd2,
      OP_START    = 4'd3,
      OP_STOP     = 4'd4,
      OP_CLEAR    = 4'd5,
      OP_SHOW     = 4'd6
   } opcodeT;  // Codes 7 to 15 do nothing.

   typedef enum logic
   {
      ST_IDLE = 1'b0,
      ST_EXEC = 1'b1
   } ctrlStateT;

endpackage

`default_nettype wire

// ==== source/tickGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tickGen
#(
   parameter int SAMPLE_DIV = 1000000,
   parameter int TIMER_DIV  = 100000,
   parameter int SCAN_DIV   = 100000
)
(
   input  wire  selected_clk,
   input  wire  res,
   output logic sampleTick,
   output logic timerTick,
   output logic scanTick
);

   logic [2:0] ticks;

   // One free-running divider per strobe.
   for (genvar i = 0; i < 3; i++)
   begin : gDiv
      localparam int DIV = (i == 0) ? SAMPLE_DIV : (i == 1) ? TIMER_DIV : SCAN_DIV;
      localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

      logic [CW-1:0] cnt;

      always_ff @(posedge selected_clk or posedge res)
      begin
         if (res)
         begin
            cnt <= '0;
            ticks[i] <= 1'b0;
         end
         else if (cnt == CW'(DIV - 1))
         begin
            cnt <= '0;
            ticks[i] <= 1'b1;  // Wrap gives a single-cycle enable.
         end
         else
         begin
            cnt <= cnt + 1'b1;
            ticks[i] <= 1'b0;
         end
      end
   end

   assign sampleTick = ticks[0];
   assign timerTick = ticks[1];
   assign scanTick = ticks[2];

endmodule

`default_nettype wire

// ==== source/timerCtrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface timerCtrlIf;
   import boardPkg::*;

   logic              run;        // Level, timer counts while high.
   logic              clear;      // Strobe.
   logic              loadArr;    // Strobe.
   logic [DATA_W-1:0] arrValue;
   logic [DATA_W-1:0] tmr;
   logic [DATA_W-1:0] ctr;
   logic              arReached;  // Strobe on every reload.

   modport ctrl
   (
      output run, clear, loadArr, arrValue,
      input  arReached
   );

   modport timer
   (
      input  run, clear, loadArr, arrValue,
      output tmr, ctr, arReached
   );

endinterface

`default_nettype wire

// ==== source/timerUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module timerUnit
(
   input  wire       selected_clk,
   input  wire       res,
   input  wire       timerTick,
   timerCtrlIf.timer tt
);

   // ***********************************************************
   // Auto-reload counter and reload-event counter
   // ***********************************************************
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         tt.tmr <= '0;
         tt.ctr <= '0;
         tt.arReached <= 1'b0;
      end
      else
      begin
         tt.arReached <= 1'b0;
         if (tt.clear)
         begin
            tt.tmr <= '0;
            tt.ctr <= '0;
         end
         else if (tt.loadArr)
            tt.tmr <= '0;  // A new period starts from zero.
         else if (timerTick && tt.run)
         begin
            if (tt.tmr == tt.arrValue)
            begin
               tt.tmr <= '0;
               tt.ctr <= tt.ctr + 1'b1;
               tt.arReached <= 1'b1;
            end
            else
               tt.tmr <= tt.tmr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/boardPkg.sv
source/monitorPkg.sv
source/timerCtrlIf.sv
source/tickGen.sv
source/inputSampler.sv
source/monitorCtrl.sv
source/timerUnit.sv
source/displayScan.sv
source/boardTop.sv
dv/boardTop_asserts.sv
dv/boardTop_tb.sv
